//--- src.f
hdl/imuldiv_pkg.sv
hdl/imuldiv_data_if.sv
hdl/imuldiv_ctrl.sv
hdl/imuldiv_sign_unit.sv
hdl/imuldiv_mul_dpath.sv
hdl/imuldiv_div_dpath.sv
hdl/imuldiv_iterative.sv
sim/imuldiv_checker.sv
sim/imuldiv_tb.sv

//--- Bender.yml
package:
  name: imuldiv

sources:
  - hdl/imuldiv_pkg.sv
  - hdl/imuldiv_data_if.sv
  - hdl/imuldiv_ctrl.sv
  - hdl/imuldiv_sign_unit.sv
  - hdl/imuldiv_mul_dpath.sv
  - hdl/imuldiv_div_dpath.sv
  - hdl/imuldiv_iterative.sv
  - target: test
    files:
      - sim/imuldiv_checker.sv
      - sim/imuldiv_tb.sv

//--- sim/imuldiv_tb.sv
/*
 * testbench top: clock, reset, LCG stimulus with back-pressure,
 * watchdog, DUT and checker instances
 */
`timescale 1ns/1ps

module imuldiv_tb
  import imuldiv_pkg::*;
;

  localparam int WIDTH    = 32;
  // 5x5 corner pairs for 3 ops, then random mul and random div/rem
  localparam int N_CORNER = 75;
  localparam int N_MUL    = 60;
  localparam int N_DIV    = 60;
  localparam int N_REQ    = N_CORNER + N_MUL + N_DIV;

  logic               clk;
  logic               reset;
  logic [WIDTH-1:0]   req_a;
  logic [WIDTH-1:0]   req_b;
  imuldiv_op_e        req_op;
  logic               req_val;
  logic               req_rdy;
  logic [2*WIDTH-1:0] resp_result;
  logic               resp_val;
  logic               resp_rdy;
  int                 test_count;
  int                 error_count;
  logic [31:0]        lcg_state;
  int                 sent;

  imuldiv_iterative #(.WIDTH(WIDTH)) dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_op      (req_op),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  imuldiv_checker #(.WIDTH(WIDTH)) checker0 (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_op      (req_op),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .test_count  (test_count),
    .error_count (error_count)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // ----------------------------------------------------------
  // random numbers
  // ----------------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // shifted down by a random amount so small and large magnitudes both appear
  function automatic logic [WIDTH-1:0] rand_operand();
    logic [31:0] r;
    logic [31:0] s;
    r = lcg_next();
    s = lcg_next();
    r = r >> s[20:16];
    return s[24] ? -r : r;
  endfunction

  function automatic logic [WIDTH-1:0] corner_value(int idx);
    case (idx)
      0:       return '0;
      1:       return WIDTH'(1);
      2:       return '1;
      3:       return {1'b1, {(WIDTH-1){1'b0}}};
      default: return {1'b0, {(WIDTH-1){1'b1}}};
    endcase
  endfunction

  // ----------------------------------------------------------
  // one request, from offer to taken response
  // ----------------------------------------------------------

  // called and returns 1 ns after a rising edge
  task automatic run_op(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                        input imuldiv_op_e op);
    req_a   = a;
    req_b   = b;
    req_op  = op;
    req_val = 1'b1;
    @(posedge clk);
    while (!req_rdy) @(posedge clk);
    #1;
    // operands only need to hold in the accepting cycle
    req_val = 1'b0;
    req_a   = lcg_next();
    req_b   = lcg_next();
    resp_rdy = ((lcg_next() >> 16) % 3) != 0;
    @(posedge clk);
    while (!(resp_val && resp_rdy)) begin
      #1;
      resp_rdy = ((lcg_next() >> 16) % 3) != 0;
      @(posedge clk);
    end
    #1;
    resp_rdy = 1'b0;
    sent++;
  endtask

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    req_a     = '0;
    req_b     = '0;
    req_op    = OP_MUL;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    lcg_state = 32'd80;
    sent      = 0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // corner operands through all three ops
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        run_op(corner_value(i), corner_value(j), OP_MUL);
        run_op(corner_value(i), corner_value(j), OP_DIV);
        run_op(corner_value(i), corner_value(j), OP_REM);
      end
    end
    // random multiply, the unused code 3 acts as multiply
    for (int i = 0; i < N_MUL; i++) begin
      run_op(rand_operand(), rand_operand(),
             lcg_next() & 32'h0001_0000 ? imuldiv_op_e'(2'd3) : OP_MUL);
    end
    // random divide and remainder
    for (int i = 0; i < N_DIV; i++) begin
      run_op(rand_operand(), rand_operand(),
             lcg_next() & 32'h0001_0000 ? OP_REM : OP_DIV);
    end

    repeat (3) @(posedge clk);
    $display("tests %0d, errors %0d, requests sent %0d", test_count, error_count, sent);
    if (test_count != N_REQ + 1) begin
      $display("expected %0d tests but %0d finished", N_REQ + 1, test_count);
    end
    if (error_count == 0 && test_count == N_REQ + 1) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // ----------------------------------------------------------
  // watchdog
  // ----------------------------------------------------------

  initial begin
    repeat (N_REQ * (WIDTH + 20) + 200) @(posedge clk);
    $display("run timed out after %0d requests of %0d", sent, N_REQ);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- sim/imuldiv_checker.sv
/*
 * checker for the multiply/divide unit with reference model, result compare,
 * handshake, back-pressure, latency and reset checks
 */
`timescale 1ns/1ps

module imuldiv_checker
  import imuldiv_pkg::*;
#(
  parameter int WIDTH = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [WIDTH-1:0]   req_a,
  input  logic [WIDTH-1:0]   req_b,
  input  imuldiv_op_e        req_op,
  input  logic               req_val,
  input  logic               req_rdy,
  input  logic [2*WIDTH-1:0] resp_result,
  input  logic               resp_val,
  input  logic               resp_rdy,
  output int                 test_count,
  output int                 error_count
);

  logic [2*WIDTH-1:0] exp_q[$];
  string              desc_q[$];
  int unsigned        cycle;
  int unsigned        accept_cycle;
  logic               busy;
  logic               prev_reset;
  logic               prev_val;
  // response was offered but not taken last cycle
  logic               prev_hold;
  logic [2*WIDTH-1:0] prev_result;
  logic [2*WIDTH-1:0] exp_val;
  string              desc;

  // ----------------------------------------------------------
  // reference model in signed arithmetic at double width
  // ----------------------------------------------------------

  function automatic logic [2*WIDTH-1:0] model(logic [WIDTH-1:0] a, logic [WIDTH-1:0] b,
                                               imuldiv_op_e op);
    logic signed [2*WIDTH-1:0] sa;
    logic signed [2*WIDTH-1:0] sb;
    logic signed [2*WIDTH-1:0] q;
    logic signed [2*WIDTH-1:0] r;
    logic [WIDTH-1:0]          min_val;
    min_val = {1'b1, {(WIDTH-1){1'b0}}};
    sa = {{WIDTH{a[WIDTH-1]}}, a};
    sb = {{WIDTH{b[WIDTH-1]}}, b};
    if (b == '0) begin
      // divide by zero gives an all-ones quotient and the dividend as remainder
      q = '1;
      r = sa;
    end else if (a == min_val && b == '1) begin
      // overflow wraps the quotient to the most negative value
      q = sa;
      r = '0;
    end else begin
      // truncating division with the remainder following the dividend
      q = sa / sb;
      r = sa % sb;
    end
    case (op)
      OP_DIV:  return q;
      OP_REM:  return r;
      default: return sa * sb;
    endcase
  endfunction

  function automatic string op_name(imuldiv_op_e op);
    case (op)
      OP_DIV:  return "div";
      OP_REM:  return "rem";
      default: return "mul";
    endcase
  endfunction

  initial begin
    test_count  = 0;
    error_count = 0;
    cycle       = 0;
    busy        = 1'b0;
    prev_reset  = 1'b0;
    prev_val    = 1'b0;
    prev_hold   = 1'b0;
  end

  // ----------------------------------------------------------
  // sampled at the rising edge where all inputs have settled
  // ----------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      busy      = 1'b0;
      prev_val  = 1'b0;
      prev_hold = 1'b0;
      exp_q.delete();
      desc_q.delete();
    end else begin
      // first cycle out of reset
      if (prev_reset) begin
        test_count++;
        if (req_rdy !== 1'b1 || resp_val !== 1'b0) begin
          error_count++;
          if (req_rdy !== 1'b1) begin
            $display("Mismatch req_rdy after reset expected 1 actual %h", req_rdy);
          end
          if (resp_val !== 1'b0) begin
            $display("Mismatch resp_val after reset expected 0 actual %h", resp_val);
          end
          $display("test %0d reset state FAIL", test_count);
        end else begin
          $display("test %0d reset state ok", test_count);
        end
      end
      // back-pressure holds the response until it is taken
      if (prev_hold) begin
        if (resp_val !== 1'b1) begin
          error_count++;
          $display("Mismatch resp_val before the response was taken expected 1 actual %h",
                   resp_val);
        end else if (resp_result !== prev_result) begin
          error_count++;
          $display("Mismatch resp_result held %h now %h", prev_result, resp_result);
        end
      end
      if (busy && req_rdy) begin
        error_count++;
        $display("Mismatch req_rdy while a request is in flight expected 0 actual %h",
                 req_rdy);
      end
      // rise is seen one sample after the cycle it starts in
      if (resp_val && !prev_val && (cycle - accept_cycle != WIDTH + 1)) begin
        error_count++;
        $display("resp_val rose %0d cycles after the accepting edge, expected %0d",
                 cycle - accept_cycle - 1, WIDTH);
      end
      // response handshake
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("response taken with no request outstanding");
        end else begin
          exp_val = exp_q.pop_front();
          desc    = desc_q.pop_front();
          test_count++;
          if (resp_result !== exp_val) begin
            error_count++;
            $display("Mismatch resp_result expected %h actual %h", exp_val, resp_result);
            $display("test %0d %s FAIL", test_count, desc);
          end else begin
            $display("test %0d %s ok", test_count, desc);
          end
        end
        busy = 1'b0;
      end
      // request handshake
      if (req_val && req_rdy) begin
        exp_q.push_back(model(req_a, req_b, req_op));
        desc_q.push_back($sformatf("%s a=%h b=%h", op_name(req_op), req_a, req_b));
        accept_cycle = cycle;
        busy         = 1'b1;
      end
      prev_hold   = resp_val && !resp_rdy;
      prev_result = resp_result;
      prev_val    = resp_val;
    end
    prev_reset = reset;
    cycle++;
  end

endmodule

//--- hdl/imuldiv_iterative.sv
/*
 * iterative signed multiply/divide unit, top level
 * control, sign unit and both magnitude datapaths
 */
`timescale 1ns/1ps

module imuldiv_iterative
  import imuldiv_pkg::*;
#(
  parameter int WIDTH = 32
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [WIDTH-1:0]               req_a,
  input  logic [WIDTH-1:0]               req_b,
  input  imuldiv_op_e                    req_op,
  input  logic                           req_val,
  output logic                           req_rdy,
  output logic [result_width(WIDTH)-1:0] resp_result,
  output logic                           resp_val,
  input  logic                           resp_rdy
);

  // load pulses on acceptance, step is high through calc
  logic load;
  logic step;

  imuldiv_data_if #(.WIDTH(WIDTH)) data_if ();

  // ----------------------------------------------------------
  // sequencing
  // ----------------------------------------------------------

  imuldiv_ctrl #(.WIDTH(WIDTH)) ctrl0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .load     (load),
    .step     (step)
  );

  // ----------------------------------------------------------
  // sign handling and result select
  // ----------------------------------------------------------

  imuldiv_sign_unit #(.WIDTH(WIDTH)) sign0 (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_op      (req_op),
    .data        (data_if.sign_mp),
    .resp_result (resp_result)
  );

  // both datapaths run on every request
  imuldiv_mul_dpath #(.WIDTH(WIDTH)) mul0 (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .step  (step),
    .data  (data_if.mul_mp)
  );

  imuldiv_div_dpath #(.WIDTH(WIDTH)) div0 (
    .clk   (clk),
    .reset (reset),
    .load  (load),
    .step  (step),
    .data  (data_if.div_mp)
  );

endmodule

//--- hdl/imuldiv_div_dpath.sv
/*
 * restoring magnitude divider, one quotient bit per step
 */
`timescale 1ns/1ps

module imuldiv_div_dpath #(
  parameter int WIDTH = 32
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           load,
  input  logic           step,
  imuldiv_data_if.div_mp data
);

  logic [WIDTH-1:0] rem_reg;
  // dividend bits shift out the top, quotient bits shift in the bottom
  logic [WIDTH-1:0] quo_reg;
  logic [WIDTH-1:0] divisor_reg;
  logic [WIDTH:0]   shifted;
  logic [WIDTH+1:0] diff;
  logic             neg;

  // ----------------------------------------------------------
  // trial subtract
  // ----------------------------------------------------------

  // bring down the next dividend bit
  assign shifted = {rem_reg, quo_reg[WIDTH-1]};
  // one extra bit so a borrow shows up as the sign
  assign diff    = {1'b0, shifted} - {2'b00, divisor_reg};
  assign neg     = diff[WIDTH+1];

  always_ff @(posedge clk) begin
    if (reset) begin
      rem_reg <= '0;
      quo_reg <= '0;
    end else if (load) begin
      rem_reg <= '0;
      quo_reg <= data.mag_a;
    end else if (step) begin
      // restore on borrow, otherwise keep the difference
      rem_reg <= neg ? shifted[WIDTH-1:0] : diff[WIDTH-1:0];
      quo_reg <= {quo_reg[WIDTH-2:0], ~neg};
    end
  end

  // divisor magnitude held for the whole run
  always_ff @(posedge clk) begin
    if (load) begin
      divisor_reg <= data.mag_b;
    end
  end

  // zero divisor never borrows: quotient all ones, remainder the dividend
  assign data.quotient  = quo_reg;
  assign data.remainder = rem_reg;

endmodule

//--- hdl/imuldiv_mul_dpath.sv
/*
 * shift-add magnitude multiplier, one bit per step
 */
`timescale 1ns/1ps

module imuldiv_mul_dpath #(
  parameter int WIDTH = 32
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           load,
  input  logic           step,
  imuldiv_data_if.mul_mp data
);

  logic [2*WIDTH-1:0] acc_reg;
  // multiplicand, shifted left each step
  logic [2*WIDTH-1:0] mcand_reg;
  // multiplier, shifted right each step
  logic [WIDTH-1:0]   mplier_reg;
  logic [2*WIDTH-1:0] acc_next;

  // add the shifted multiplicand when the current multiplier bit is set
  assign acc_next = mplier_reg[0] ? (acc_reg + mcand_reg) : acc_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_reg    <= '0;
      mplier_reg <= '0;
    end else if (load) begin
      acc_reg    <= '0;
      mplier_reg <= data.mag_b;
    end else if (step) begin
      acc_reg    <= acc_next;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  // multiplicand register
  always_ff @(posedge clk) begin
    if (load) begin
      mcand_reg <= {{WIDTH{1'b0}}, data.mag_a};
    end else if (step) begin
      mcand_reg <= mcand_reg << 1;
    end
  end

  // after WIDTH steps the accumulator holds the full product
  assign data.product = acc_reg;

endmodule

//--- hdl/imuldiv_sign_unit.sv
/*
 * operand unsigning, sign and opcode capture,
 * final sign correction and result select
 */
`timescale 1ns/1ps

module imuldiv_sign_unit
  import imuldiv_pkg::*;
#(
  parameter int WIDTH = 32
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           load,
  input  logic [WIDTH-1:0]               req_a,
  input  logic [WIDTH-1:0]               req_b,
  input  imuldiv_op_e                    req_op,
  imuldiv_data_if.sign_mp                data,
  output logic [result_width(WIDTH)-1:0] resp_result
);

  localparam int RW = result_width(WIDTH);

  logic             sign_a_reg;
  logic             sign_b_reg;
  logic             b_zero_reg;
  imuldiv_op_e      op_reg;
  logic [RW-1:0]    prod_signed;
  logic [WIDTH-1:0] quo_signed;
  logic [WIDTH-1:0] rem_signed;

  // ----------------------------------------------------------
  // operand magnitudes
  // ----------------------------------------------------------

  // two's complement magnitude, most negative value maps to itself
  assign data.mag_a = req_a[WIDTH-1] ? -req_a : req_a;
  assign data.mag_b = req_b[WIDTH-1] ? -req_b : req_b;

  // capture signs and opcode for the end of the run
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a_reg <= 1'b0;
      sign_b_reg <= 1'b0;
      b_zero_reg <= 1'b0;
      op_reg     <= OP_MUL;
    end else if (load) begin
      sign_a_reg <= req_a[WIDTH-1];
      sign_b_reg <= req_b[WIDTH-1];
      b_zero_reg <= (req_b == '0);
      op_reg     <= req_op;
    end
  end

  // ----------------------------------------------------------
  // sign correction
  // ----------------------------------------------------------

  // product sign follows the xor of the operand signs
  assign prod_signed = (sign_a_reg ^ sign_b_reg) ? -data.product : data.product;

  // divide by zero forces all ones regardless of signs
  assign quo_signed = b_zero_reg ? '1 :
                      ((sign_a_reg ^ sign_b_reg) ? -data.quotient : data.quotient);

  // remainder takes the sign of the dividend
  assign rem_signed = sign_a_reg ? -data.remainder : data.remainder;

  // result select, division results sign-extended
  always_comb begin
    case (op_reg)
      OP_DIV:  resp_result = {{WIDTH{quo_signed[WIDTH-1]}}, quo_signed};
      OP_REM:  resp_result = {{WIDTH{rem_signed[WIDTH-1]}}, rem_signed};
      default: resp_result = prod_signed;
    endcase
  end

endmodule

//--- hdl/imuldiv_ctrl.sv
/*
 * control FSM for the iterative multiply/divide unit
 * sequences load, WIDTH step cycles and the response
 */
`timescale 1ns/1ps

module imuldiv_ctrl #(
  parameter int WIDTH = 32
) (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  input  logic resp_rdy,
  output logic req_rdy,
  output logic resp_val,
  output logic load,
  output logic step
);

  localparam int CNT_W = $clog2(WIDTH);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] count;
  logic             req_go;
  logic             resp_go;
  logic             last_step;

  // ----------------------------------------------------------
  // handshakes
  // ----------------------------------------------------------

  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  // counter runs 0 .. WIDTH-1 while in calc
  assign last_step = (count == CNT_W'(WIDTH - 1));

  // ----------------------------------------------------------
  // state and step counter
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          // accept, datapaths load on this same edge
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (last_step) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          // hold the response until it is taken
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // outputs, decoded from state
  // ----------------------------------------------------------

  assign req_rdy  = (state == st_idle);
  assign load     = req_go;
  assign step     = (state == st_calc);
  assign resp_val = (state == st_done);

endmodule

//--- hdl/imuldiv_data_if.sv
/*
 * operand magnitudes and raw unsigned results
 * between the sign unit and the two datapaths
 */
`timescale 1ns/1ps

interface imuldiv_data_if #(
  parameter int WIDTH = 32
);

  // operand magnitudes, combinational from the request
  logic [WIDTH-1:0]   mag_a;
  logic [WIDTH-1:0]   mag_b;

  // raw magnitude results
  logic [2*WIDTH-1:0] product;
  logic [WIDTH-1:0]   quotient;
  logic [WIDTH-1:0]   remainder;

  // sign unit feeds magnitudes in and picks a result out
  modport sign_mp (
    output mag_a, mag_b,
    input  product, quotient, remainder
  );

  // shift-add multiplier
  modport mul_mp (
    input  mag_a, mag_b,
    output product
  );

  // restoring divider
  modport div_mp (
    input  mag_a, mag_b,
    output quotient, remainder
  );

endinterface

//--- hdl/imuldiv_pkg.sv
/*
 * shared definitions for the iterative multiply/divide unit
 * operation code type and result width helper
 */
package imuldiv_pkg;

  // ----------------------------------------------------------
  // operation code
  // ----------------------------------------------------------

  // encoding 3 is unused; the sign unit treats it as multiply
  typedef enum logic [1:0] {
    OP_MUL = 2'd0,
    OP_DIV = 2'd1,
    OP_REM = 2'd2
  } imuldiv_op_e;

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------

  // full product and sign-extended division results share this width
  function automatic int unsigned result_width(int unsigned width);
    return 2 * width;
  endfunction

endpackage
